// ==== hdl/mem_pkg.sv ====
package mem_pkg;

    localparam int XLEN = 32;
    localparam int SEL_W = 4;
    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    // Instructions per fetch pair
    localparam int FETCH_WIDTH = 2;
    localparam int SLOT_W = $clog2(FETCH_WIDTH);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(FETCH_WIDTH - 1);

    typedef enum logic [2:0] {
        LD_B  = 3'd0,
        LD_BU = 3'd1,
        LD_H  = 3'd2,
        LD_HU = 3'd3,
        LD_W  = 3'd4,
        ST_B  = 3'd5,
        ST_H  = 3'd6,
        ST_W  = 3'd7
    } lsu_op_e;

    // Plain strobe-and-response bus, one transaction in flight
    typedef struct packed {
        logic             valid;
        logic             we;
        logic [XLEN-1:0]  addr;
        logic [SEL_W-1:0] sel;
        logic [XLEN-1:0]  wdata;
    } bus_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic                             valid;
        logic [XLEN-1:0]                  pc;
        logic [FETCH_WIDTH-1:0][XLEN-1:0] instr;
    } fetch_pair_t;

    typedef struct packed {
        logic            valid;
        lsu_op_e         op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_op_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] rdata;
    } mem_result_t;

endpackage

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 fetch_en_i,
    input  logic                 ib_stall_i,
    input  logic                 redirect_i,
    input  logic [31:0]          redirect_pc_i,
    output mem_pkg::bus_req_t    bus_req_o,
    input  mem_pkg::bus_rsp_t    bus_rsp_i,
    output mem_pkg::fetch_pair_t fetch_pair_o
);

    logic [mem_pkg::XLEN-1:0] pc_q;
    logic [mem_pkg::XLEN-1:0] addr_q;
    logic [mem_pkg::SLOT_W-1:0] slot_q;
    logic req_q;
    logic discard_q;
    logic pair_valid_q;
    logic [mem_pkg::FETCH_WIDTH-1:0][mem_pkg::XLEN-1:0] instr_q;

    logic issue;
    logic fill;
    logic accept;

    // New read only when idle and the pair slot is free
    assign issue = fetch_en_i && !redirect_i && !req_q && !pair_valid_q;

    // Stale responses after a redirect are dropped
    assign fill = bus_rsp_i.valid && req_q && !discard_q && !redirect_i;

    assign accept = pair_valid_q && !ib_stall_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q         <= mem_pkg::RESET_PC;
            addr_q       <= mem_pkg::RESET_PC;
            slot_q       <= '0;
            req_q        <= 1'b0;
            discard_q    <= 1'b0;
            pair_valid_q <= 1'b0;
        end else begin
            // Request level held until the response pulse
            if (bus_rsp_i.valid) begin
                req_q <= 1'b0;
            end else if (issue) begin
                req_q <= 1'b1;
            end

            if (redirect_i) begin
                pc_q         <= redirect_pc_i;
                // An outstanding read keeps its address until the response
                if (!req_q || bus_rsp_i.valid) begin
                    addr_q <= redirect_pc_i;
                end
                slot_q       <= '0;
                pair_valid_q <= 1'b0;
                // Read still outstanding past this cycle
                discard_q    <= req_q && !bus_rsp_i.valid;
            end else begin
                if (bus_rsp_i.valid) begin
                    discard_q <= 1'b0;
                    // Stale read done, resume at the redirect target
                    if (discard_q) begin
                        addr_q <= pc_q;
                    end
                end
                if (fill) begin
                    addr_q <= addr_q + 32'd4;
                    if (slot_q == mem_pkg::LAST_SLOT) begin
                        slot_q       <= '0;
                        pair_valid_q <= 1'b1;
                    end else begin
                        slot_q <= slot_q + 1'b1;
                    end
                end
                // addr_q already points past the pair
                if (accept) begin
                    pc_q         <= addr_q;
                    pair_valid_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            instr_q[slot_q] <= bus_rsp_i.rdata;
        end
    end

    always_comb begin
        bus_req_o       = '0;
        bus_req_o.valid = req_q;
        bus_req_o.addr  = addr_q;
        bus_req_o.sel   = '1;
    end

    assign fetch_pair_o.valid = pair_valid_q;
    assign fetch_pair_o.pc    = pc_q;
    assign fetch_pair_o.instr = instr_q;

    // A held pair blocks further bus reads
    assert property (@(posedge clk) disable iff (!rst_n_i)
        fetch_pair_o.valid |-> !bus_req_o.valid)
        else $error("fetch_unit: bus read while a pair is presented");

endmodule

// ==== hdl/lsu_port.sv ====
`timescale 1ns/100ps

module lsu_port (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  mem_pkg::mem_op_t     mem_op_i,
    output logic                 data_busy_o,
    output mem_pkg::mem_result_t mem_result_o,
    output mem_pkg::bus_req_t    bus_req_o,
    input  mem_pkg::bus_rsp_t    bus_rsp_i
);

    mem_pkg::mem_op_t op_q;
    logic busy_q;
    logic result_valid_q;
    logic [mem_pkg::XLEN-1:0] result_data_q;

    logic accept;
    logic is_store;
    logic [1:0] offset;
    logic [mem_pkg::SEL_W-1:0] sel;
    logic [mem_pkg::XLEN-1:0] wdata_lane;
    logic [7:0] rd_byte;
    logic [15:0] rd_half;
    logic [mem_pkg::XLEN-1:0] load_data;

    assign accept   = mem_op_i.valid && !busy_q;
    assign offset   = op_q.addr[1:0];
    assign is_store = op_q.op inside {mem_pkg::ST_B, mem_pkg::ST_H, mem_pkg::ST_W};

    // Byte selects and write data copied into every lane
    always_comb begin
        case (op_q.op)
            mem_pkg::LD_B, mem_pkg::LD_BU, mem_pkg::ST_B: begin
                sel        = 4'b0001 << offset;
                wdata_lane = {4{op_q.wdata[7:0]}};
            end
            mem_pkg::LD_H, mem_pkg::LD_HU, mem_pkg::ST_H: begin
                sel        = 4'b0011 << offset;
                wdata_lane = {2{op_q.wdata[15:0]}};
            end
            default: begin
                sel        = '1;
                wdata_lane = op_q.wdata;
            end
        endcase
    end

    assign rd_byte = bus_rsp_i.rdata[{offset, 3'b000} +: 8];
    assign rd_half = bus_rsp_i.rdata[{offset[1], 4'b0000} +: 16];

    always_comb begin
        case (op_q.op)
            mem_pkg::LD_B:  load_data = {{24{rd_byte[7]}}, rd_byte};
            mem_pkg::LD_BU: load_data = {24'b0, rd_byte};
            mem_pkg::LD_H:  load_data = {{16{rd_half[15]}}, rd_half};
            mem_pkg::LD_HU: load_data = {16'b0, rd_half};
            mem_pkg::LD_W:  load_data = bus_rsp_i.rdata;
            // Stores return no data
            default:        load_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q         <= 1'b0;
            result_valid_q <= 1'b0;
        end else begin
            if (bus_rsp_i.valid) begin
                busy_q <= 1'b0;
            end else if (accept) begin
                busy_q <= 1'b1;
            end
            result_valid_q <= bus_rsp_i.valid && busy_q;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= mem_op_i;
        end
        if (bus_rsp_i.valid) begin
            result_data_q <= load_data;
        end
    end

    always_comb begin
        bus_req_o       = '0;
        bus_req_o.valid = busy_q;
        bus_req_o.we    = is_store;
        bus_req_o.addr  = {op_q.addr[31:2], 2'b00};
        bus_req_o.sel   = sel;
        bus_req_o.wdata = wdata_lane;
    end

    assign data_busy_o        = busy_q;
    assign mem_result_o.valid = result_valid_q;
    assign mem_result_o.rdata = result_data_q;

    assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_op_i.valid && (mem_op_i.op inside {mem_pkg::LD_H, mem_pkg::LD_HU, mem_pkg::ST_H})
        |-> !mem_op_i.addr[0])
        else $error("lsu_port: odd halfword address");

    assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_op_i.valid && (mem_op_i.op inside {mem_pkg::LD_W, mem_pkg::ST_W})
        |-> mem_op_i.addr[1:0] == 2'b00)
        else $error("lsu_port: unaligned word address");

    // Back end must wait for the previous result
    assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_op_i.valid |-> !data_busy_o)
        else $error("lsu_port: operation issued while busy");

endmodule

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/100ps

module bus_arbiter (
    input  logic              clk,
    input  logic              rst_n_i,
    input  mem_pkg::bus_req_t fetch_req_i,
    output mem_pkg::bus_rsp_t fetch_rsp_o,
    input  mem_pkg::bus_req_t data_req_i,
    output mem_pkg::bus_rsp_t data_rsp_o,
    output mem_pkg::bus_req_t bus_req_o,
    input  mem_pkg::bus_rsp_t bus_rsp_i
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FETCH,
        ARB_DATA
    } arb_state_e;

    arb_state_e state_q;
    arb_state_e state_d;

    logic grant_fetch;
    logic grant_data;

    // Data side wins when both ask from idle
    assign grant_data  = (state_q == ARB_DATA) ||
                         (state_q == ARB_IDLE && data_req_i.valid);
    assign grant_fetch = (state_q == ARB_FETCH) ||
                         (state_q == ARB_IDLE && !data_req_i.valid && fetch_req_i.valid);

    always_comb begin
        state_d = state_q;
        if (bus_rsp_i.valid) begin
            // Also covers a zero-latency reply straight from idle
            state_d = ARB_IDLE;
        end else if (state_q == ARB_IDLE) begin
            if (grant_data) begin
                state_d = ARB_DATA;
            end else if (grant_fetch) begin
                state_d = ARB_FETCH;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        if (grant_data) begin
            bus_req_o = data_req_i;
        end else if (grant_fetch) begin
            bus_req_o = fetch_req_i;
        end else begin
            bus_req_o = '0;
        end
    end

    always_comb begin
        fetch_rsp_o       = '0;
        data_rsp_o        = '0;
        fetch_rsp_o.rdata = bus_rsp_i.rdata;
        data_rsp_o.rdata  = bus_rsp_i.rdata;
        fetch_rsp_o.valid = bus_rsp_i.valid && grant_fetch;
        data_rsp_o.valid  = bus_rsp_i.valid && grant_data;
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        bus_rsp_i.valid |-> (grant_fetch || grant_data))
        else $error("bus_arbiter: response without a grant");

    // Granted peer keeps its request level until the response
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (state_q == ARB_FETCH) |-> fetch_req_i.valid)
        else $error("bus_arbiter: fetch request dropped during grant");

endmodule

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/100ps

module mem_subsys_top (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 fetch_en_i,
    input  logic                 ib_stall_i,
    input  logic                 redirect_i,
    input  logic [31:0]          redirect_pc_i,
    output mem_pkg::fetch_pair_t fetch_pair_o,
    input  mem_pkg::mem_op_t     mem_op_i,
    output mem_pkg::mem_result_t mem_result_o,
    output logic                 data_busy_o,
    output mem_pkg::bus_req_t    bus_req_o,
    input  mem_pkg::bus_rsp_t    bus_rsp_i
);

    // Peer side of the arbiter
    mem_pkg::bus_req_t fetch_bus_req;
    mem_pkg::bus_rsp_t fetch_bus_rsp;
    mem_pkg::bus_req_t data_bus_req;
    mem_pkg::bus_rsp_t data_bus_rsp;

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fetch_en_i   (fetch_en_i),
        .ib_stall_i   (ib_stall_i),
        .redirect_i   (redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .bus_req_o    (fetch_bus_req),
        .bus_rsp_i    (fetch_bus_rsp),
        .fetch_pair_o (fetch_pair_o)
    );

    lsu_port u_lsu_port (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .mem_op_i    (mem_op_i),
        .data_busy_o (data_busy_o),
        .mem_result_o(mem_result_o),
        .bus_req_o   (data_bus_req),
        .bus_rsp_i   (data_bus_rsp)
    );

    bus_arbiter u_bus_arbiter (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .fetch_req_i(fetch_bus_req),
        .fetch_rsp_o(fetch_bus_rsp),
        .data_req_i (data_bus_req),
        .data_rsp_o (data_bus_rsp),
        .bus_req_o  (bus_req_o),
        .bus_rsp_i  (bus_rsp_i)
    );

endmodule

// ==== verif/mem_model.sv ====
`timescale 1ns/100ps

module mem_model (
    input  logic              clk,
    input  logic              rst_n_i,
    input  mem_pkg::bus_req_t bus_req_i,
    output mem_pkg::bus_rsp_t bus_rsp_o
);

    // Sparse storage; unwritten words read back the fill pattern
    logic [31:0] mem [logic [31:0]];
    logic active;
    int unsigned lat;
    int unsigned wait_cnt;

    function automatic logic [31:0] read_word(input logic [31:0] key);
        if (mem.exists(key)) begin
            return mem[key];
        end
        return key ^ 32'ha5a5_0000;
    endfunction

    always @(posedge clk or negedge rst_n_i) begin
        logic [31:0] key;
        logic [31:0] word;
        if (!rst_n_i) begin
            bus_rsp_o <= '0;
            active = 1'b0;
            lat = 0;
            wait_cnt = 0;
        end else begin
            bus_rsp_o.valid <= 1'b0;
            // Requester drops its level at the edge that sees the pulse
            if (!bus_rsp_o.valid && bus_req_i.valid) begin
                if (!active) begin
                    active = 1'b1;
                    lat = $urandom % 4;
                    wait_cnt = 0;
                end
                if (wait_cnt == lat) begin
                    key = {bus_req_i.addr[31:2], 2'b00};
                    word = read_word(key);
                    if (bus_req_i.we) begin
                        for (int i = 0; i < 4; i++) begin
                            if (bus_req_i.sel[i]) begin
                                word[8*i +: 8] = bus_req_i.wdata[8*i +: 8];
                            end
                        end
                        mem[key] = word;
                        bus_rsp_o.rdata <= '0;
                    end else begin
                        bus_rsp_o.rdata <= word;
                    end
                    bus_rsp_o.valid <= 1'b1;
                    active = 1'b0;
                end else begin
                    wait_cnt = wait_cnt + 1;
                end
            end
        end
    end

endmodule

// ==== verif/tb_mem_subsys.sv ====
`timescale 1ns/100ps

module tb_mem_subsys;

    localparam int CLK_PERIOD = 100;
    localparam int WAIT_LIMIT = 200;
    // Rough count of bus transactions over all tests, worst cycles per transaction
    localparam int TXN_COUNT = 110;
    localparam int TXN_CYCLES = 8;
    localparam int MARGIN_CYCLES = 400;
    localparam logic [31:0] JUMP_PC = 32'h1c00_4000;
    localparam logic [31:0] RESUME_PC = 32'h1c00_8000;

    logic clk;
    logic rst_n;
    logic fetch_en;
    logic ib_stall;
    logic redirect;
    logic [31:0] redirect_pc;
    mem_pkg::fetch_pair_t fetch_pair;
    mem_pkg::mem_op_t mem_op;
    mem_pkg::mem_result_t mem_result;
    logic data_busy;
    mem_pkg::bus_req_t bus_req;
    mem_pkg::bus_rsp_t bus_rsp;

    int errors;
    int checks;
    logic [31:0] next_pc;
    // Expected memory contents after stores
    logic [31:0] shadow [logic [31:0]];

    mem_subsys_top u_mem_subsys_top (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .fetch_en_i   (fetch_en),
        .ib_stall_i   (ib_stall),
        .redirect_i   (redirect),
        .redirect_pc_i(redirect_pc),
        .fetch_pair_o (fetch_pair),
        .mem_op_i     (mem_op),
        .mem_result_o (mem_result),
        .data_busy_o  (data_busy),
        .bus_req_o    (bus_req),
        .bus_rsp_i    (bus_rsp)
    );

    mem_model u_mem_model (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .bus_req_i(bus_req),
        .bus_rsp_o(bus_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] key;
        key = {addr[31:2], 2'b00};
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return key ^ 32'ha5a5_0000;
    endfunction

    function automatic logic [31:0] expected_load(input mem_pkg::lsu_op_e op,
                                                  input logic [31:0] addr);
        logic [31:0] w;
        logic [7:0] b;
        logic [15:0] h;
        int off;
        w = expected_word(addr);
        off = int'(addr[1:0]);
        b = w[8*off +: 8];
        h = w[8*(off & 2) +: 16];
        case (op)
            mem_pkg::LD_B:  return 32'($signed(b));
            mem_pkg::LD_BU: return {24'h0, b};
            mem_pkg::LD_H:  return 32'($signed(h));
            mem_pkg::LD_HU: return {16'h0, h};
            default:        return w;
        endcase
    endfunction

    task automatic record_store(input mem_pkg::lsu_op_e op, input logic [31:0] addr,
                                input logic [31:0] data);
        logic [31:0] w;
        int off;
        w = expected_word(addr);
        off = int'(addr[1:0]);
        if (op == mem_pkg::ST_B) begin
            w[8*off +: 8] = data[7:0];
        end else if (op == mem_pkg::ST_H) begin
            w[8*off +: 16] = data[15:0];
        end else begin
            w = data;
        end
        shadow[{addr[31:2], 2'b00}] = w;
    endtask

    task automatic wait_pair(output logic found);
        int n;
        n = 0;
        @(negedge clk);
        while (!fetch_pair.valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        found = fetch_pair.valid;
        if (!found) begin
            errors++;
            $display("Timeout at %0t: no fetch pair was presented", $time);
        end
    endtask

    task automatic check_pair(input logic [31:0] exp_pc);
        logic found;
        wait_pair(found);
        if (found) begin
            check_value("pair pc", fetch_pair.pc, exp_pc);
            check_value("pair instr 0", fetch_pair.instr[0], expected_word(exp_pc));
            check_value("pair instr 1", fetch_pair.instr[1], expected_word(exp_pc + 32'd4));
        end
    endtask

    // Issue one data operation and check its result
    task automatic data_op(input mem_pkg::lsu_op_e op, input logic [31:0] addr,
                           input logic [31:0] wdata);
        int n;
        logic [31:0] exp;
        n = 0;
        exp = expected_load(op, addr);
        @(negedge clk);
        while (data_busy && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        mem_op.valid = 1'b1;
        mem_op.op = op;
        mem_op.addr = addr;
        mem_op.wdata = wdata;
        @(negedge clk);
        mem_op.valid = 1'b0;
        n = 0;
        while (!mem_result.valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!mem_result.valid) begin
            errors++;
            $display("Timeout at %0t: data operation at %h never completed", $time, addr);
        end else if (op inside {mem_pkg::ST_B, mem_pkg::ST_H, mem_pkg::ST_W}) begin
            record_store(op, addr, wdata);
        end else begin
            check_value($sformatf("load op %0d at %h", op, addr), mem_result.rdata, exp);
        end
    endtask

    task automatic test_fetch_start();
        next_pc = mem_pkg::RESET_PC;
        for (int i = 0; i < 3; i++) begin
            check_pair(next_pc);
            next_pc = next_pc + 32'd8;
        end
    endtask

    task automatic test_fetch_stall();
        logic found;
        mem_pkg::fetch_pair_t held;
        @(negedge clk);
        ib_stall = 1'b1;
        wait_pair(found);
        if (found) begin
            held = fetch_pair;
            check_value("stalled pc", held.pc, next_pc);
            repeat (6) begin
                @(negedge clk);
                check_value("stalled valid", 32'(fetch_pair.valid), 32'd1);
                check_value("stalled pc hold", fetch_pair.pc, held.pc);
                check_value("stalled instr 0", fetch_pair.instr[0], held.instr[0]);
                check_value("stalled instr 1", fetch_pair.instr[1], held.instr[1]);
            end
        end
        ib_stall = 1'b0;
        next_pc = next_pc + 32'd8;
        check_pair(next_pc);
        next_pc = next_pc + 32'd8;
    endtask

    task automatic test_redirect();
        int n;
        n = 0;
        // Wait for the second read of a pair to be in flight
        @(negedge clk);
        while (!(bus_req.valid && bus_req.addr == next_pc + 32'd4) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            errors++;
            $display("Timeout at %0t: second fetch read never seen", $time);
        end
        redirect = 1'b1;
        redirect_pc = JUMP_PC;
        @(negedge clk);
        redirect = 1'b0;
        next_pc = JUMP_PC;
        for (int i = 0; i < 2; i++) begin
            check_pair(next_pc);
            next_pc = next_pc + 32'd8;
        end
    endtask

    task automatic test_load_kinds();
        logic [31:0] base;
        @(negedge clk);
        fetch_en = 1'b0;
        for (int w = 0; w < 2; w++) begin
            base = (w == 0) ? 32'h0000_2000 : 32'h0000_2084;
            for (int off = 0; off < 4; off++) begin
                data_op(mem_pkg::LD_B, base + 32'(off), 32'h0);
                data_op(mem_pkg::LD_BU, base + 32'(off), 32'h0);
            end
            for (int off = 0; off < 4; off += 2) begin
                data_op(mem_pkg::LD_H, base + 32'(off), 32'h0);
                data_op(mem_pkg::LD_HU, base + 32'(off), 32'h0);
            end
            data_op(mem_pkg::LD_W, base, 32'h0);
        end
    endtask

    task automatic test_store_widths();
        data_op(mem_pkg::ST_B, 32'h0000_3001, 32'h1122_335a);
        data_op(mem_pkg::LD_W, 32'h0000_3000, 32'h0);
        data_op(mem_pkg::ST_B, 32'h0000_3003, $urandom);
        data_op(mem_pkg::LD_W, 32'h0000_3000, 32'h0);
        data_op(mem_pkg::ST_H, 32'h0000_3006, 32'h7777_beef);
        data_op(mem_pkg::LD_W, 32'h0000_3004, 32'h0);
        data_op(mem_pkg::ST_H, 32'h0000_3004, $urandom);
        data_op(mem_pkg::LD_W, 32'h0000_3004, 32'h0);
        data_op(mem_pkg::ST_W, 32'h0000_3008, 32'h1234_5678);
        data_op(mem_pkg::LD_W, 32'h0000_3008, 32'h0);
    endtask

    task automatic test_concurrent();
        @(negedge clk);
        fetch_en = 1'b1;
        redirect = 1'b1;
        redirect_pc = RESUME_PC;
        @(negedge clk);
        redirect = 1'b0;
        next_pc = RESUME_PC;
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    check_pair(next_pc);
                    next_pc = next_pc + 32'd8;
                end
            end
            begin
                mem_pkg::lsu_op_e op;
                logic [31:0] addr;
                for (int i = 0; i < 10; i++) begin
                    op = mem_pkg::lsu_op_e'(3'($urandom % 8));
                    addr = 32'h0000_4000 + 32'(($urandom % 4) * 4);
                    if (op inside {mem_pkg::LD_B, mem_pkg::LD_BU, mem_pkg::ST_B}) begin
                        addr = addr + 32'($urandom % 4);
                    end else if (op inside {mem_pkg::LD_H, mem_pkg::LD_HU, mem_pkg::ST_H}) begin
                        addr = addr + 32'(($urandom % 2) * 2);
                    end
                    data_op(op, addr, $urandom);
                end
            end
        join
    endtask

    initial begin
        void'($urandom(32'h34e6_eff6));
        errors = 0;
        checks = 0;
        clk = 1'b0;
        rst_n = 1'b0;
        fetch_en = 1'b0;
        ib_stall = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        mem_op = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("pair valid after reset", 32'(fetch_pair.valid), 32'd0);
        check_value("result valid after reset", 32'(mem_result.valid), 32'd0);
        check_value("busy after reset", 32'(data_busy), 32'd0);
        check_value("bus valid after reset", 32'(bus_req.valid), 32'd0);
        rst_n = 1'b1;
        fetch_en = 1'b1;
        test_fetch_start();
        test_fetch_stall();
        test_redirect();
        test_load_kinds();
        test_store_widths();
        test_concurrent();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (TXN_COUNT * TXN_CYCLES + MARGIN_CYCLES));
        $display("Watchdog expired at %0t: the tests did not finish in time", $time);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
hdl/mem_pkg.sv
hdl/fetch_unit.sv
hdl/lsu_port.sv
hdl/bus_arbiter.sv
hdl/mem_subsys_top.sv
verif/mem_model.sv
verif/tb_mem_subsys.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_subsys \
    -f list.f --Mdir obj_dir -o tb_mem_subsys

out=$(./obj_dir/tb_mem_subsys)
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
else
    exit 1
fi
